// File: common/soc_settings.svh
// ==========================================================================
// Build constants for the SoC bus fabric: bus widths, slave count, reset
// hold time, interrupt vector base and the slave address windows.
// Include this file wherever one of these constants is needed.
// ==========================================================================
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

`define SOC_DATA_W       16
`define SOC_ADDR_W       20                   // Tag bit plus 19-bit word address
`define SOC_NUM_SLAVES   6
`define SOC_NUM_IRQ      8
`define SOC_RST_HOLD     8                    // Cycles of reset after rst_lck rises
`define SOC_IRQ_VEC_BASE 16'd8                // Vector of irq line 0
`define SOC_DEFAULT_DATA {`SOC_DATA_W{1'b1}}  // Unmapped read value

// Windows as {tga, adr[19:1]}, compared only where the mask bit is set
`define SOC_WIN_ROM_ADDR    20'b0_1111_1111_1111_0000_000 // mem FFF00-FFFFF
`define SOC_WIN_ROM_MASK    20'b1_1111_1111_1111_0000_000
`define SOC_WIN_VGAMEM_ADDR 20'b0_1010_0000_0000_0000_000 // mem A0000-BFFFF
`define SOC_WIN_VGAMEM_MASK 20'b1_1110_0000_0000_0000_000
`define SOC_WIN_VGAIO_ADDR  20'b1_0000_0000_0011_1100_000 // io 3C0-3DF
`define SOC_WIN_VGAIO_MASK  20'b1_0000_1111_1111_1110_000
`define SOC_WIN_UART_ADDR   20'b1_0000_0000_0011_1111_100 // io 3F8-3FF
`define SOC_WIN_UART_MASK   20'b1_0000_1111_1111_1111_100
`define SOC_WIN_KEYB_ADDR   20'b1_0000_0000_0000_0110_000 // io 60 and 64
`define SOC_WIN_KEYB_MASK   20'b1_0000_1111_1111_1111_101
`define SOC_WIN_TIMER_ADDR  20'b1_0000_0000_0000_0100_000 // io 40-43
`define SOC_WIN_TIMER_MASK  20'b1_0000_1111_1111_1111_110
`define SOC_WIN_RAM_ADDR    20'b0_0000_0000_0000_0000_000 // Any memory cycle
`define SOC_WIN_RAM_MASK    20'b1_0000_0000_0000_0000_000

`endif

// File: common/soc_pkg.sv
// ==========================================================================
// Bus types shared by the fabric: the tagged master address with its
// memory and I/O views, Wishbone request and response words, and the
// slave select produced by the address decoder.
// ==========================================================================
`default_nettype none

package soc_pkg;

  `include "soc_settings.svh"

  // Memory cycle, tga low, word address
  typedef struct packed {
    logic                    tga;
    logic [`SOC_ADDR_W-2:0]  word;
  } mem_addr_t;

  // I/O cycle, tga high, port byte address shifted down by one
  typedef struct packed {
    logic                    tga;
    logic [`SOC_ADDR_W-18:0] spare;  // Above the 16-bit port field
    logic [15:0]             port;
  } io_addr_t;

  typedef union packed {
    mem_addr_t mem;
    io_addr_t  io;
  } bus_addr_u;

  typedef struct packed {
    logic                   cyc;
    logic                   stb;
    logic                   we;
    logic [1:0]             sel;   // Byte lanes
    bus_addr_u              adr;
    logic [`SOC_DATA_W-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic [`SOC_DATA_W-1:0] dat;
    logic                   ack;
  } wb_rsp_t;

  // hit low means the default slave answers
  typedef struct packed {
    logic                               hit;
    logic [$clog2(`SOC_NUM_SLAVES)-1:0] idx;
  } slave_sel_t;

endpackage

`default_nettype wire

// File: src/reset_stretch.sv
// ==========================================================================
// Power-on reset stretcher. Holds the active-high system reset for a
// fixed number of clocks after the external active-low reset is released.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module reset_stretch (
  input  logic clk,
  input  logic rst_lck,  // External reset, active low
  output logic rst_o
);

  localparam int CNT_W = $clog2(`SOC_RST_HOLD + 1);

  logic [CNT_W-1:0] hold_cnt;

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      hold_cnt <= CNT_W'(`SOC_RST_HOLD);  // Reload while held
      rst_o    <= 1'b1;
    end else begin
      if (hold_cnt != '0) hold_cnt <= hold_cnt - 1'b1;
      rst_o <= (hold_cnt != '0);
    end
  end

endmodule

`default_nettype wire

// File: bus_switch/addr_decode.sv
// ==========================================================================
// Address decoder for the bus switch. Matches the tagged master address
// against the masked slave windows; the lowest slave index wins, and a
// miss leaves hit low so the default slave answers.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module addr_decode (
  input  soc_pkg::bus_addr_u  adr_i,
  output soc_pkg::slave_sel_t sel_o
);

  import soc_pkg::*;

  logic [`SOC_NUM_SLAVES-1:0] win_hit;

  // Memory windows look at the tag and the full word address
  function automatic logic mem_hit(input bus_addr_u a, input logic [`SOC_ADDR_W-1:0] base,
                                   input logic [`SOC_ADDR_W-1:0] mask);
    logic [`SOC_ADDR_W-1:0] diff;
    diff = {a.mem.tga, a.mem.word} ^ base;
    return (diff & mask) == '0;
  endfunction

  // I/O windows look at the tag and the port field only
  function automatic logic io_hit(input bus_addr_u a, input logic [`SOC_ADDR_W-1:0] base,
                                  input logic [`SOC_ADDR_W-1:0] mask);
    logic [16:0] diff;
    diff = {a.io.tga, a.io.port} ^ {base[`SOC_ADDR_W-1], base[15:0]};
    return (diff & {mask[`SOC_ADDR_W-1], mask[15:0]}) == '0;
  endfunction

  always_comb begin
    win_hit    = '0;
    win_hit[0] = mem_hit(adr_i, `SOC_WIN_ROM_ADDR, `SOC_WIN_ROM_MASK);
    win_hit[1] = mem_hit(adr_i, `SOC_WIN_VGAMEM_ADDR, `SOC_WIN_VGAMEM_MASK)
               | io_hit(adr_i, `SOC_WIN_VGAIO_ADDR, `SOC_WIN_VGAIO_MASK);
    win_hit[2] = io_hit(adr_i, `SOC_WIN_UART_ADDR, `SOC_WIN_UART_MASK);
    win_hit[3] = io_hit(adr_i, `SOC_WIN_KEYB_ADDR, `SOC_WIN_KEYB_MASK);
    win_hit[4] = io_hit(adr_i, `SOC_WIN_TIMER_ADDR, `SOC_WIN_TIMER_MASK);
    win_hit[5] = mem_hit(adr_i, `SOC_WIN_RAM_ADDR, `SOC_WIN_RAM_MASK);
  end

  // Scan downwards so the lowest matching index is left in sel_o
  always_comb begin
    sel_o = '0;
    for (int s = `SOC_NUM_SLAVES - 1; s >= 0; s--) begin
      if (win_hit[s]) begin
        sel_o.hit = 1'b1;
        sel_o.idx = ($clog2(`SOC_NUM_SLAVES))'(s);
      end
    end
  end

endmodule

`default_nettype wire

// File: bus_switch/bus_switch.sv
// ==========================================================================
// Wishbone address switch. Fans the master request out to the slave
// bank, strobes only the decoded slave and returns its response. Cycles
// that hit no window are answered at once by a built-in default slave.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module bus_switch (
  input  logic                                         clk,
  input  logic                                         rst,
  input  soc_pkg::wb_req_t                             m_req_i,
  output soc_pkg::wb_rsp_t                             m_rsp_o,
  output soc_pkg::wb_req_t [`SOC_NUM_SLAVES-1:0] s_req_o,
  input  soc_pkg::wb_rsp_t [`SOC_NUM_SLAVES-1:0] s_rsp_i
);

  import soc_pkg::*;

  slave_sel_t                 dec_sel;
  slave_sel_t                 route;
  slave_sel_t                 route_q;
  logic                       held;     // Cycle started, waiting for ack
  logic [`SOC_NUM_SLAVES-1:0] slv_sel;
  logic                       req;
  logic                       def_stb;

  addr_decode u_addr_decode (
    .adr_i (m_req_i.adr),
    .sel_o (dec_sel)
  );

  // Keep the route of a cycle fixed until it is acknowledged
  assign route = held ? route_q : dec_sel;

  always_ff @(posedge clk) begin
    route_q <= route;
    if (rst) begin
      held <= 1'b0;
    end else begin
      held <= m_req_i.cyc & m_req_i.stb & ~m_rsp_o.ack;
    end
  end

  assign req     = m_req_i.cyc & m_req_i.stb & ~rst;
  assign def_stb = req & ~route.hit;  // Default slave strobe

  always_comb begin
    for (int s = 0; s < `SOC_NUM_SLAVES; s++) begin
      slv_sel[s]     = route.hit && (route.idx == ($clog2(`SOC_NUM_SLAVES))'(s));
      s_req_o[s]     = m_req_i;  // Shared adr, we, sel and data
      s_req_o[s].cyc = m_req_i.cyc & slv_sel[s] & ~rst;
      s_req_o[s].stb = m_req_i.stb & slv_sel[s] & ~rst;
    end
  end

  always_comb begin
    m_rsp_o.dat = `SOC_DEFAULT_DATA;
    m_rsp_o.ack = def_stb;  // Acks with stb, zero wait
    for (int s = 0; s < `SOC_NUM_SLAVES; s++) begin
      if (slv_sel[s]) begin
        m_rsp_o.dat = s_rsp_i[s].dat;
        m_rsp_o.ack = s_rsp_i[s].ack & s_req_o[s].stb;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/irq_ctrl.sv
// ==========================================================================
// Interrupt controller. Rising edges on the request lines set pending
// bits, the lowest pending line is shown as the interrupt id, and an
// acknowledge pulse from the CPU clears that line.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module irq_ctrl (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [`SOC_NUM_IRQ-1:0]          irq_i,
  input  logic                             inta_i,
  output logic                             intr_o,
  output logic [$clog2(`SOC_NUM_IRQ)-1:0]  iid_o
);

  logic [`SOC_NUM_IRQ-1:0] irq_q;    // Request lines one clock ago
  logic [`SOC_NUM_IRQ-1:0] irq_rise;
  logic [`SOC_NUM_IRQ-1:0] pending;
  logic [`SOC_NUM_IRQ-1:0] ack_clr;

  assign irq_rise = irq_i & ~irq_q;

  // Lowest pending line has priority
  always_comb begin
    iid_o = '0;
    for (int n = `SOC_NUM_IRQ - 1; n >= 0; n--) begin
      if (pending[n]) iid_o = ($clog2(`SOC_NUM_IRQ))'(n);
    end
  end

  always_comb begin
    ack_clr        = '0;
    ack_clr[iid_o] = inta_i;
  end

  always_ff @(posedge clk) begin
    irq_q <= irq_i;  // Tracks lines in reset too, no edge on release
    if (rst) begin
      pending <= '0;
      intr_o  <= 1'b0;
    end else begin
      // A new edge on the line being acknowledged is kept
      pending <= (pending & ~ack_clr) | irq_rise;
      intr_o  <= |pending;
    end
  end

endmodule

`default_nettype wire

// File: src/soc_fabric.sv
// ==========================================================================
// Bus fabric top. Joins the reset stretcher, the address switch and the
// interrupt controller, and puts the interrupt vector on the master read
// data while the CPU acknowledges an interrupt.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module soc_fabric (
  input  logic                                   clk,
  input  logic                                   rst_lck,
  input  soc_pkg::wb_req_t                       m_req_i,
  output soc_pkg::wb_rsp_t                       m_rsp_o,
  output soc_pkg::wb_req_t [`SOC_NUM_SLAVES-1:0] s_req_o,
  input  soc_pkg::wb_rsp_t [`SOC_NUM_SLAVES-1:0] s_rsp_i,
  input  logic [`SOC_NUM_IRQ-1:0]                irq_i,
  input  logic                                   inta_i,
  output logic                                   intr_o,
  output logic                                   sys_rst_o
);

  import soc_pkg::*;

  logic                            sys_rst;
  wb_rsp_t                         sw_rsp;
  logic [$clog2(`SOC_NUM_IRQ)-1:0] iid;

  reset_stretch u_reset_stretch (
    .clk     (clk),
    .rst_lck (rst_lck),
    .rst_o   (sys_rst)
  );

  bus_switch u_bus_switch (
    .clk     (clk),
    .rst     (sys_rst),
    .m_req_i (m_req_i),
    .m_rsp_o (sw_rsp),
    .s_req_o (s_req_o),
    .s_rsp_i (s_rsp_i)
  );

  irq_ctrl u_irq_ctrl (
    .clk    (clk),
    .rst    (sys_rst),
    .irq_i  (irq_i),
    .inta_i (inta_i),
    .intr_o (intr_o),
    .iid_o  (iid)
  );

  always_comb begin
    m_rsp_o = sw_rsp;
    if (inta_i) m_rsp_o.dat = `SOC_IRQ_VEC_BASE + iid;  // Vector fetch
  end

  assign sys_rst_o = sys_rst;

endmodule

`default_nettype wire

// File: test/tb_slave_model.sv
// ==========================================================================
// Behavioural bank of Wishbone slaves for the fabric testbench. Each slave
// acks after a random 0 to 3 wait states and returns its own index in the
// top nibble of the read data, with the low address bits below it.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module tb_slave_model (
  input  logic                                   clk,
  input  logic                                   rst_i,  // System reset, active high
  input  soc_pkg::wb_req_t [`SOC_NUM_SLAVES-1:0] s_req_i,
  output soc_pkg::wb_rsp_t [`SOC_NUM_SLAVES-1:0] s_rsp_o
);

  import soc_pkg::*;

  logic [1:0] delay [`SOC_NUM_SLAVES];  // Wait states for the next cycle
  logic [1:0] count [`SOC_NUM_SLAVES];

  always_comb begin
    for (int s = 0; s < `SOC_NUM_SLAVES; s++) begin
      s_rsp_o[s].dat = {4'(s), s_req_i[s].adr.mem.word[11:0]};
      s_rsp_o[s].ack = s_req_i[s].stb && (count[s] == delay[s]);
    end
  end

  always @(posedge clk) begin
    for (int s = 0; s < `SOC_NUM_SLAVES; s++) begin
      if (rst_i) begin
        count[s] <= 2'd0;
        delay[s] <= 2'd0;
      end else if (s_req_i[s].stb) begin
        if (count[s] == delay[s]) begin
          count[s] <= 2'd0;
          delay[s] <= 2'($urandom_range(0, 3));  // Fresh delay per cycle
        end else begin
          count[s] <= count[s] + 2'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: test/tb_soc_fabric.sv
// ==========================================================================
// Testbench for the SoC bus fabric. Drives random master cycles and irq
// edges into the DUT, predicts routing, read data and interrupt vectors
// with its own model and stops at the first wrong result.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "soc_settings.svh"

module tb_soc_fabric;

  import soc_pkg::*;

  localparam int SEED         = 80;
  localparam int RESET_CYCLES = 16;
  localparam int N_BUS        = 200;
  localparam int IRQ_ROUNDS   = 20;
  // Bus cycle at most 5 edges, irq round at most 30 edges, doubled for margin
  localparam int TIMEOUT_CYCLES =
    2 * (RESET_CYCLES + `SOC_RST_HOLD + 2 + N_BUS * 5 + IRQ_ROUNDS * 30);

  logic                                   clk;
  logic                                   rst_lck;
  wb_req_t                                m_req;
  wb_rsp_t                                m_rsp;
  wb_req_t [`SOC_NUM_SLAVES-1:0]          s_req;
  wb_rsp_t [`SOC_NUM_SLAVES-1:0]          s_rsp;
  logic    [`SOC_NUM_IRQ-1:0]             irq;
  logic                                   inta;
  logic                                   intr;
  logic                                   sys_rst;
  logic    [`SOC_NUM_SLAVES-1:0]          stb_vec;
  logic    [`SOC_NUM_SLAVES-1:0]          cyc_vec;
  logic    [`SOC_NUM_IRQ-1:0]             model_pend;  // Expected pending lines
  logic    [`SOC_NUM_IRQ-1:0]             edges;
  logic    [15:0]                         exp_vec;
  int                                     cycles = 0;

  soc_fabric DUT (
    .clk       (clk),
    .rst_lck   (rst_lck),
    .m_req_i   (m_req),
    .m_rsp_o   (m_rsp),
    .s_req_o   (s_req),
    .s_rsp_i   (s_rsp),
    .irq_i     (irq),
    .inta_i    (inta),
    .intr_o    (intr),
    .sys_rst_o (sys_rst)
  );

  tb_slave_model u_slaves (
    .clk     (clk),
    .rst_i   (sys_rst),
    .s_req_i (s_req),
    .s_rsp_o (s_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always_comb begin
    for (int s = 0; s < `SOC_NUM_SLAVES; s++) begin
      stb_vec[s] = s_req[s].stb;
      cyc_vec[s] = s_req[s].cyc;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) halt_with_error("timeout, run took too many cycles");
  end

  task automatic stop_on_mismatch(input string test, input logic [63:0] exp,
                                  input logic [63:0] act);
    $display("mismatch %s: expected %0h, actual %0h", test, exp, act);
    $display("Something failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic halt_with_error(input string what);
    $display("error: %s", what);
    $display("Something failed");
    $fatal(1, "stopped at first error");
  endtask

  // Address drawn from one of the windows or from anywhere
  function automatic logic [19:0] pick_addr();
    logic [18:0] w;
    logic [15:0] p;
    w = 19'($urandom);
    p = 16'($urandom);
    case (3'($urandom_range(0, 7)))
      3'd0:    return {1'b0, 12'hFFF, w[6:0]};             // Boot ROM
      3'd1:    return {1'b0, 3'b101, w[15:0]};             // Video memory
      3'd2:    return {1'b1, w[18:16], 12'h01E, p[3:0]};   // Video ports
      3'd3:    return {1'b1, w[18:16], 14'h007F, p[1:0]};  // Serial port
      3'd4:    return {1'b1, w[18:16], 14'h000C, p[0], 1'b0};
      3'd5:    return {1'b1, w[18:16], 15'h0010, p[0]};    // Timer
      3'd6:    return {1'b1, w[18:16], p};                 // Mostly unmapped I/O
      default: return {1'b0, w};
    endcase
  endfunction

  // Window table in byte and port terms with -1 for the default slave
  function automatic int predict_slave(input logic [19:0] a);
    int b;
    if (!a[19]) begin
      b = int'({a[18:0], 1'b0});
      if (b >= 'hFFF00) return 0;
      if (b >= 'hA0000 && b <= 'hBFFFF) return 1;
      return 5;
    end
    b = int'({a[14:0], 1'b0});  // 16-bit I/O byte port
    if (b >= 'h3C0 && b <= 'h3DF) return 1;
    if (b >= 'h3F8 && b <= 'h3FF) return 2;
    if (b == 'h60 || b == 'h64) return 3;
    if (b >= 'h40 && b <= 'h43) return 4;
    return -1;
  endfunction

  function automatic int lowest_set(input logic [`SOC_NUM_IRQ-1:0] p);
    for (int n = 0; n < `SOC_NUM_IRQ; n++) begin
      if (p[n]) return n;
    end
    return 0;
  endfunction

  task automatic run_bus_cycle(input logic [19:0] a);
    int                         exp_slave;
    logic [`SOC_NUM_SLAVES-1:0] exp_stb;
    logic [15:0]                exp_dat;
    string                      name;
    bit                         done;
    int                         waits;
    logic                       wr_en;
    logic [1:0]                 lanes;
    logic [15:0]                wdat;
    exp_slave = predict_slave(a);
    if (exp_slave < 0) begin
      name    = "default slave";
      exp_stb = '0;
      exp_dat = `SOC_DEFAULT_DATA;
    end else begin
      name    = "read data";
      exp_stb = `SOC_NUM_SLAVES'(1 << exp_slave);
      exp_dat = {4'(exp_slave), a[11:0]};
    end
    @(posedge clk);
    wr_en = 1'($urandom);
    lanes = 2'($urandom);
    wdat  = 16'($urandom);
    m_req.cyc <= 1'b1;
    m_req.stb <= 1'b1;
    m_req.we  <= wr_en;
    m_req.sel <= lanes;
    m_req.adr <= a;
    m_req.dat <= wdat;
    done  = 1'b0;
    waits = 0;
    while (!done) begin
      @(negedge clk);
      assert (stb_vec == exp_stb)
        else stop_on_mismatch("routing", 64'(exp_stb), 64'(stb_vec));
      assert (cyc_vec == exp_stb)
        else stop_on_mismatch("slave cyc", 64'(exp_stb), 64'(cyc_vec));
      // Every slave sees the master's adr, we, sel and data
      for (int s = 0; s < `SOC_NUM_SLAVES; s++) begin
        assert ({s_req[s].we, s_req[s].sel, s_req[s].adr, s_req[s].dat}
                == {wr_en, lanes, a, wdat})
          else stop_on_mismatch("fan-out", 64'({wr_en, lanes, a, wdat}),
                                64'({s_req[s].we, s_req[s].sel, s_req[s].adr,
                                     s_req[s].dat}));
      end
      if (m_rsp.ack) begin
        assert (m_rsp.dat == exp_dat)
          else stop_on_mismatch(name, 64'(exp_dat), 64'(m_rsp.dat));
        done = 1'b1;
      end else begin
        assert (exp_slave >= 0)
          else halt_with_error("default slave did not ack in the same cycle as stb");
        assert (waits < 3) else halt_with_error("slave ack came after more than 3 waits");
        waits++;
        @(posedge clk);
      end
    end
  endtask

  initial begin
    void'($urandom(SEED));
    rst_lck = 1'b0;
    m_req   = '0;
    irq     = '0;
    inta    = 1'b0;

    // Live requests during reset must never reach a slave
    for (int c = 1; c < RESET_CYCLES; c++) begin
      @(posedge clk);
      m_req.cyc <= 1'b1;
      m_req.stb <= 1'b1;
      m_req.adr <= pick_addr();
      @(negedge clk);
      assert (stb_vec == '0 && cyc_vec == '0 && !m_rsp.ack)
        else halt_with_error("slave strobe, slave cyc or master ack seen during reset");
    end
    @(posedge clk);
    rst_lck   <= 1'b1;
    m_req.cyc <= 1'b0;
    m_req.stb <= 1'b0;
    @(posedge clk);  // First edge that samples rst_lck high
    for (int k = 0; k <= `SOC_RST_HOLD; k++) begin
      @(negedge clk);
      assert (sys_rst == (k < `SOC_RST_HOLD))
        else stop_on_mismatch("reset", 64'(k < `SOC_RST_HOLD), 64'(sys_rst));
    end

    for (int i = 0; i < N_BUS; i++) run_bus_cycle(pick_addr());
    @(posedge clk);
    m_req.cyc <= 1'b0;
    m_req.stb <= 1'b0;

    for (int r = 0; r < IRQ_ROUNDS; r++) begin
      edges = `SOC_NUM_IRQ'($urandom);
      if (edges == '0) edges = `SOC_NUM_IRQ'(1);
      @(posedge clk);
      irq <= edges;
      @(posedge clk);
      irq <= '0;
      model_pend = edges;
      @(negedge clk);
      while (!intr) @(negedge clk);
      // One inta pulse per pending line with the lowest line first
      while (model_pend != '0) begin
        exp_vec = `SOC_IRQ_VEC_BASE + 16'(lowest_set(model_pend));
        @(posedge clk);
        inta <= 1'b1;
        @(negedge clk);
        assert (m_rsp.dat == exp_vec)
          else stop_on_mismatch("interrupt", 64'(exp_vec), 64'(m_rsp.dat));
        @(posedge clk);
        inta <= 1'b0;
        model_pend[lowest_set(model_pend)] = 1'b0;
      end
      @(posedge clk);
      @(negedge clk);
      assert (!intr) else halt_with_error("intr still high after every line was acknowledged");
    end

    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+common
common/soc_pkg.sv
src/reset_stretch.sv
bus_switch/addr_decode.sv
bus_switch/bus_switch.sv
src/irq_ctrl.sv
src/soc_fabric.sv
test/tb_slave_model.sv
test/tb_soc_fabric.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the bus fabric testbench with Verilator and runs it.
# The exit status is that of the simulation.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -j 0 \
  --top-module tb_soc_fabric -Mdir obj_dir -f build.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator compile step returned status $status"
  exit $status
fi

./obj_dir/Vtb_soc_fabric
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation returned status $status"
  exit $status
fi
exit 0
